// File: id_stage.f
+incdir+common
+incdir+test
common/id_pkg.sv
common/id_dec_if.sv
decoder/id_decoder.sv
hdl/id_operand_mux.sv
id_ctrl/id_ex_ctrl.sv
hdl/id_stage.sv
test/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compile the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -f id_stage.f --top-module tb_id_stage \
  -o tb_id_stage > build.log 2>&1 &&
./obj_dir/tb_id_stage > sim.log 2>&1 ||
{ echo "Build or run error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: test/tb_id_vectors.svh
//////////////////////////////
// Decode test table and LFSR
// Included inside tb_id_stage only
//////////////////////////////
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        lsb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    lsb       = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
    val = {val[30:0], lsb};
  end
  return val;
endfunction

// Columns: instr, taken, op, a_sel, b_sel, we, lsu, store, ill, pc_set cycle, multi
task automatic load_table();
  add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
  add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), 0, 1, 0, 0, 1, 0, 0, 0, 0, 0);
  add_row(enc_r(7'h20, 5'd4, 5'd5, 3'd5, 5'd6, 7'h33), 0, 7, 0, 0, 1, 0, 0, 0, 0, 0);
  add_row(enc_r(7'h00, 5'd4, 5'd5, 3'd3, 5'd6, 7'h33), 0, 9, 0, 0, 1, 0, 0, 0, 0, 0);
  add_row(enc_i(12'hffb, 5'd1, 3'd0, 5'd4, 7'h13), 0, 0, 0, 1, 1, 0, 0, 0, 0, 0);
  add_row(enc_i(12'h7f0, 5'd1, 3'd7, 5'd4, 7'h13), 0, 4, 0, 1, 1, 0, 0, 0, 0, 0);
  add_row(enc_i(12'h403, 5'd1, 3'd5, 5'd4, 7'h13), 0, 7, 0, 1, 1, 0, 0, 0, 0, 0);
  add_row(enc_u(20'hABCDE, 5'd5, 7'h37), 0, 0, 3, 4, 1, 0, 0, 0, 0, 0);
  add_row(enc_u(20'h80001, 5'd6, 7'h17), 0, 0, 2, 4, 1, 0, 0, 0, 0, 0);
  add_row(enc_i(12'h804, 5'd1, 3'd2, 5'd7, 7'h03), 0, 0, 0, 1, 1, 1, 0, 0, 0, 1);
  add_row(enc_i(12'h011, 5'd2, 3'd4, 5'd7, 7'h03), 0, 0, 0, 1, 1, 1, 0, 0, 0, 1);
  add_row(enc_s(12'h7fc, 5'd2, 5'd1, 3'd2, 7'h23), 0, 0, 0, 2, 0, 1, 1, 0, 0, 1);
  add_row(enc_b(13'h1ff0, 5'd2, 5'd1, 3'd0, 7'h63), 1, 10, 0, 0, 0, 0, 0, 0, 2, 1);
  add_row(enc_b(13'h0040, 5'd2, 5'd1, 3'd6, 7'h63), 0, 14, 0, 0, 0, 0, 0, 0, 0, 0);
  add_row(enc_b(13'h0808, 5'd3, 5'd4, 3'd1, 7'h63), 1, 11, 0, 0, 0, 0, 0, 0, 2, 1);
  add_row(enc_j(21'h1ffffc, 5'd1, 7'h6f), 0, 0, 2, 5, 1, 0, 0, 0, 1, 1);
  add_row(enc_i(12'h010, 5'd1, 3'd0, 5'd1, 7'h67), 0, 0, 2, 5, 1, 0, 0, 0, 1, 1);
  // Unknown opcode, mul encoding and a bad load size
  add_row(enc_i(12'h000, 5'd1, 3'd0, 5'd1, 7'h0b), 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
  add_row(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
  add_row(enc_i(12'h000, 5'd1, 3'd3, 5'd1, 7'h03), 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
endtask

`endif

// File: test/tb_id_stage.sv
//////////////////////////////
// Testbench for the decode stage
// Table rows run one at a time
//////////////////////////////
`timescale 1ns/10ps

module tb_id_stage;
  import id_pkg::*;

  typedef struct {
    logic [31:0] instr;
    bit          taken;
    logic [4:0]  op;
    logic [1:0]  a_sel;
    logic [2:0]  b_sel;
    bit          we, lsu, store, ill, multi;
    int          pcs;
  } row_t;

  localparam int NUM_ROWS  = 20;
  localparam int MAX_DELAY = 4;
  // Reset, rows at worst case latency, fetch enable check and margin
  localparam int WATCHDOG_NS = (8 + NUM_ROWS * (MAX_DELAY + 3) + 30) * 20;

  logic clk_i, rst_ni, fetch_enable_i, instr_valid_i, branch_decision_i;
  logic ex_valid_i, lsu_resp_valid_i, lsu_addr_incr_req_i;
  logic [31:0] instr_rdata_i, pc_id_i, result_ex_i, lsu_addr_last_i;
  logic [31:0] rf_rdata_a_i, rf_rdata_b_i;
  logic id_in_ready_o, illegal_insn_o, pc_set_o, instr_id_done_o;
  logic lsu_req_o, lsu_we_o, lsu_sign_ext_o, rf_ren_a_o, rf_ren_b_o, rf_we_o;
  alu_op_e alu_operator_o;
  lsu_type_e lsu_type_o;
  logic [31:0] alu_operand_a_o, alu_operand_b_o, lsu_wdata_o, rf_wdata_o;
  logic [4:0] rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;

  row_t rows[$];
  logic [15:0] lfsr_state = 16'd53873;
  int errors = 0;

  // Instruction encoders from the RV32I formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction
  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction
  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction
  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction
  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  function automatic void add_row(logic [31:0] instr, bit taken, logic [4:0] op,
                                  logic [1:0] a_sel, logic [2:0] b_sel, bit we, bit lsu,
                                  bit store, bit ill, int pcs, bit multi);
    row_t r;
    r = '{instr, taken, op, a_sel, b_sel, we, lsu, store, ill, multi, pcs};
    rows.push_back(r);
  endfunction

  `include "tb_id_vectors.svh"

  id_stage uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic log_mismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Operand values from the immediate rules
  // Sel codes 0 reg, 1 I, 2 S, 4 U, 5 incr
  function automatic logic [31:0] expect_b(logic [2:0] sel, logic [31:0] in);
    case (sel)
      3'd1:    return {{20{in[31]}}, in[31:20]};
      3'd2:    return {{20{in[31]}}, in[31:25], in[11:7]};
      3'd4:    return {in[31:12], 12'b0};
      3'd5:    return 32'd4;
      default: return rf_rdata_b_i;
    endcase
  endfunction

  function automatic logic [31:0] expect_a(logic [1:0] sel);
    case (sel)
      2'd2:    return pc_id_i;
      2'd3:    return 32'd0;
      default: return rf_rdata_a_i;
    endcase
  endfunction

  // rs1 is read by every format except U and J (LUI, AUIPC, JAL)
  function automatic bit reads_rs1(logic [6:0] opc);
    return !(opc inside {7'h37, 7'h17, 7'h6f});
  endfunction

  // rs2 is read by the R, S and B formats (OP, STORE, BRANCH)
  function automatic bit reads_rs2(logic [6:0] opc);
    return opc inside {7'h33, 7'h23, 7'h63};
  endfunction

  // Access size of a load or store from its funct3
  function automatic lsu_type_e access_size(logic [2:0] f3);
    case (f3[1:0])
      2'd0:    return LSU_BYTE;
      2'd1:    return LSU_HALF;
      default: return LSU_WORD;
    endcase
  endfunction

  task automatic check_decode(input row_t r);
    if (illegal_insn_o !== r.ill) log_mismatch("illegal_insn_o wrong");
    if (!r.ill && alu_operator_o !== r.op) log_mismatch("alu operator wrong");
    if (!r.ill && alu_operand_a_o !== expect_a(r.a_sel)) log_mismatch("operand A wrong");
    if (!r.ill && alu_operand_b_o !== expect_b(r.b_sel, r.instr))
      log_mismatch("operand B wrong");
    if (r.store && lsu_wdata_o !== rf_rdata_b_i) log_mismatch("store data wrong");
    // Register fields sit at fixed positions in every format
    if (rf_raddr_a_o !== r.instr[19:15]) log_mismatch("rf_raddr_a_o wrong");
    if (rf_raddr_b_o !== r.instr[24:20]) log_mismatch("rf_raddr_b_o wrong");
    if (rf_waddr_o !== r.instr[11:7]) log_mismatch("rf_waddr_o wrong");
    if (rf_ren_a_o !== (!r.ill && reads_rs1(r.instr[6:0])))
      log_mismatch("rf_ren_a_o wrong");
    if (rf_ren_b_o !== (!r.ill && reads_rs2(r.instr[6:0])))
      log_mismatch("rf_ren_b_o wrong");
    if (lsu_we_o !== r.store) log_mismatch("lsu_we_o wrong");
    if (r.lsu && lsu_type_o !== access_size(r.instr[14:12]))
      log_mismatch("lsu_type_o wrong");
    // LB, LH and LW sign extend, LBU and LHU do not
    if (r.lsu && !r.store &&
        lsu_sign_ext_o !== (r.instr[14:12] inside {3'd0, 3'd1, 3'd2}))
      log_mismatch("lsu_sign_ext_o wrong");
    // Second access of a misaligned pair
    if (r.lsu) begin
      lsu_addr_incr_req_i = 1'b1;
      #1;
      if (alu_operand_a_o !== lsu_addr_last_i || alu_operand_b_o !== 32'd4)
        log_mismatch("address increment operands wrong");
      lsu_addr_incr_req_i = 1'b0;
      #1;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   delay, exp_done, cyc, lsu_cnt, pcs_cyc;
    bit   done;
    r        = rows[idx];
    delay    = 1 + int'(rand_bits(2));
    exp_done = r.multi ? delay + 1 : 1;
    cyc      = 1;
    lsu_cnt  = 0;
    pcs_cyc  = 0;
    done     = 1'b0;
    @(negedge clk_i);
    instr_valid_i     = 1'b1;
    instr_rdata_i     = r.instr;
    branch_decision_i = r.taken;
    pc_id_i           = rand_bits(32);
    rf_rdata_a_i      = rand_bits(32);
    rf_rdata_b_i      = rand_bits(32);
    result_ex_i       = rand_bits(32);
    lsu_addr_last_i   = rand_bits(32);
    while (!done) begin
      // LSU response and EX valid arrive after the drawn delay
      ex_valid_i       = (cyc > delay);
      lsu_resp_valid_i = (cyc > delay);
      #1;
      if (cyc == 1) check_decode(r);
      if (lsu_req_o) begin
        lsu_cnt++;
        if (cyc != 1) log_mismatch("lsu_req_o outside first cycle");
      end
      if (pc_set_o) begin
        if (pcs_cyc != 0) log_mismatch("second pc_set_o pulse");
        pcs_cyc = cyc;
      end
      done = instr_id_done_o;
      if (rf_we_o !== (r.we && done)) log_mismatch("rf_we_o wrong");
      if (rf_we_o && rf_wdata_o !== result_ex_i) log_mismatch("rf_wdata_o wrong");
      if (id_in_ready_o !== done) log_mismatch("id_in_ready_o wrong");
      if (done && cyc != exp_done) log_mismatch("instruction finished in wrong cycle");
      if (!done && cyc > 20) begin
        $display("Row %0d did not finish within 20 cycles", idx);
        errors++;
        done = 1'b1;
      end
      if (!done) begin
        @(negedge clk_i);
        cyc++;
      end
    end
    if (lsu_cnt != int'(r.lsu)) log_mismatch("wrong number of lsu_req_o pulses");
    if (pcs_cyc != r.pcs) log_mismatch("pc_set_o in wrong cycle or missing");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    fetch_enable_i = 1'b1;
    instr_valid_i = 1'b0;
    branch_decision_i = 1'b0;
    ex_valid_i = 1'b0;
    lsu_resp_valid_i = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    instr_rdata_i = '0;
    pc_id_i = '0;
    result_ex_i = '0;
    lsu_addr_last_i = '0;
    rf_rdata_a_i = '0;
    rf_rdata_b_i = '0;
    load_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (pc_set_o !== 1'b0 || lsu_req_o !== 1'b0 || rf_we_o !== 1'b0 ||
        instr_id_done_o !== 1'b0)
      log_mismatch("outputs not idle after reset");
    for (int i = 0; i < rows.size(); i++) run_row(i);
    // Nothing may finish while fetch is disabled
    @(negedge clk_i);
    fetch_enable_i = 1'b0;
    instr_rdata_i  = rows[0].instr;
    ex_valid_i     = 1'b1;
    repeat (3) begin
      #1;
      if (instr_id_done_o !== 1'b0 || rf_we_o !== 1'b0)
        log_mismatch("instruction finished with fetch disabled");
      @(negedge clk_i);
    end
    instr_valid_i  = 1'b0;
    fetch_enable_i = 1'b1;
    $display("Tests done with %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/id_stage.sv
//////////////////////////////
// RV32I decode stage top level
// Instruction held until id_in_ready_o
//////////////////////////////
`timescale 1ns/10ps
`include "id_cfg.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_enable_i,
  // Fetch side
  input  logic                   instr_valid_i,
  input  logic [`ID_XLEN-1:0]    instr_rdata_i,
  input  logic [`ID_XLEN-1:0]    pc_id_i,
  output logic                   id_in_ready_o,
  output logic                   illegal_insn_o,
  output logic                   pc_set_o,
  output logic                   instr_id_done_o,
  // EX side
  input  logic                   branch_decision_i,
  input  logic                   ex_valid_i,
  input  logic [`ID_XLEN-1:0]    result_ex_i,
  output id_pkg::alu_op_e        alu_operator_o,
  output logic [`ID_XLEN-1:0]    alu_operand_a_o,
  output logic [`ID_XLEN-1:0]    alu_operand_b_o,
  // LSU
  input  logic                   lsu_resp_valid_i,
  input  logic                   lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0]    lsu_addr_last_i,
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output id_pkg::lsu_type_e      lsu_type_o,
  output logic                   lsu_sign_ext_o,
  output logic [`ID_XLEN-1:0]    lsu_wdata_o,
  // Register file
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  output logic [`ID_RADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0] rf_raddr_b_o,
  output logic [`ID_RADDR_W-1:0] rf_waddr_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic                   rf_we_o,
  output logic [`ID_XLEN-1:0]    rf_wdata_o
);

  id_op_if   op_if ();
  id_ctrl_if ctrl_if ();

  // Operator goes straight to EX
  assign alu_operator_o = op_if.alu_operator;

  id_decoder u_decoder (
    .instr_rdata_i (instr_rdata_i),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr_o),
    .op            (op_if.dec),
    .ctrl          (ctrl_if.dec)
  );

  id_operand_mux u_operand_mux (
    .op                  (op_if.mux),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .pc_id_i             (pc_id_i),
    .rf_rdata_a_i        (rf_rdata_a_i),
    .rf_rdata_b_i        (rf_rdata_b_i),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o)
  );

  id_ex_ctrl u_ex_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .result_ex_i       (result_ex_i),
    .rf_rdata_b_i      (rf_rdata_b_i),
    .ctrl              (ctrl_if.ctrl),
    .id_in_ready_o     (id_in_ready_o),
    .illegal_insn_o    (illegal_insn_o),
    .pc_set_o          (pc_set_o),
    .instr_id_done_o   (instr_id_done_o),
    .lsu_req_o         (lsu_req_o),
    .lsu_we_o          (lsu_we_o),
    .lsu_sign_ext_o    (lsu_sign_ext_o),
    .lsu_type_o        (lsu_type_o),
    .lsu_wdata_o       (lsu_wdata_o),
    .rf_ren_a_o        (rf_ren_a_o),
    .rf_ren_b_o        (rf_ren_b_o),
    .rf_we_o           (rf_we_o),
    .rf_wdata_o        (rf_wdata_o)
  );

endmodule

// File: id_ctrl/id_ex_ctrl.sv
//////////////////////////////
// ID/EX control for the two-stage setup
// No writeback stage, no forwarding
// One PC set per branch or jump
//////////////////////////////
`timescale 1ns/10ps
`include "id_cfg.svh"

module id_ex_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_enable_i,
  input  logic                instr_valid_i,
  input  logic                branch_decision_i,
  input  logic                ex_valid_i,
  input  logic                lsu_resp_valid_i,
  input  logic [`ID_XLEN-1:0] result_ex_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  id_ctrl_if.ctrl             ctrl,
  output logic                id_in_ready_o,
  output logic                illegal_insn_o,
  output logic                pc_set_o,
  output logic                instr_id_done_o,
  output logic                lsu_req_o,
  output logic                lsu_we_o,
  output logic                lsu_sign_ext_o,
  output id_pkg::lsu_type_e   lsu_type_o,
  output logic [`ID_XLEN-1:0] lsu_wdata_o,
  output logic                rf_ren_a_o,
  output logic                rf_ren_b_o,
  output logic                rf_we_o,
  output logic [`ID_XLEN-1:0] rf_wdata_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    instr_executing;
  logic    instr_first_cycle;
  logic    instr_done;
  logic    multicycle_done;
  logic    stall_mem, stall_branch, stall_jump;
  logic    branch_set_raw_d, branch_set_raw_q, jump_set_raw;
  logic    set_done_d, set_done_q;

  // Fetch enable stands in for the controller run state
  assign instr_executing   = instr_valid_i & fetch_enable_i;
  assign instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Memory ops wait on the LSU, branches and jumps on EX
  assign multicycle_done = ctrl.lsu_req ? lsu_resp_valid_i : ex_valid_i;

  // Loads and stores always stall their first cycle
  assign stall_mem = instr_valid_i & ctrl.lsu_req & (~lsu_resp_valid_i | instr_first_cycle);

  //////////////////////////////
  // ID/EX FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_executing) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_comb begin
    id_fsm_d         = id_fsm_q;
    stall_branch     = 1'b0;
    stall_jump       = 1'b0;
    branch_set_raw_d = 1'b0;
    jump_set_raw     = 1'b0;

    if (instr_executing) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (ctrl.lsu_req) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (ctrl.branch) begin
            // Taken branch sets the PC next cycle, not-taken retires now
            id_fsm_d         = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch     = branch_decision_i;
            branch_set_raw_d = branch_decision_i;
          end else if (ctrl.jump) begin
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = ctrl.branch;
            stall_jump   = ctrl.jump;
          end
        end
      endcase
    end
  end

  assign instr_done      = instr_executing & ~(stall_mem | stall_branch | stall_jump);
  assign instr_id_done_o = instr_done;
  assign id_in_ready_o   = ~instr_valid_i | instr_done;

  //////////////////////////////
  // PC set tracking
  //////////////////////////////

  // Set-done flop masks repeats until the instruction leaves ID
  assign set_done_d = (branch_set_raw_q | jump_set_raw | set_done_q) & ~instr_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_raw_q <= 1'b0;
      set_done_q       <= 1'b0;
    end else begin
      branch_set_raw_q <= branch_set_raw_d;
      set_done_q       <= set_done_d;
    end
  end

  assign pc_set_o = (branch_set_raw_q | jump_set_raw) & ~set_done_q;

  //////////////////////////////
  // LSU and register file
  //////////////////////////////

  // One request per access, issued in the first executing cycle
  assign lsu_req_o      = instr_executing & instr_first_cycle & ctrl.lsu_req;
  assign lsu_we_o       = ctrl.lsu_we;
  assign lsu_type_o     = ctrl.lsu_type;
  assign lsu_sign_ext_o = ctrl.lsu_sign_ext;
  assign lsu_wdata_o    = rf_rdata_b_i;

  assign illegal_insn_o = instr_valid_i & ctrl.illegal;
  assign rf_ren_a_o     = instr_valid_i & ~ctrl.illegal & ctrl.rf_ren_a;
  assign rf_ren_b_o     = instr_valid_i & ~ctrl.illegal & ctrl.rf_ren_b;

  // Write only in the finishing cycle, load data arrives with the response
  assign rf_we_o    = ctrl.rf_we & ~ctrl.illegal & instr_done;
  assign rf_wdata_o = result_ex_i;

endmodule

// File: hdl/id_operand_mux.sv
//////////////////////////////
// ALU operand selection, combinational
// Misaligned second access overrides decode
//////////////////////////////
`timescale 1ns/10ps
`include "id_cfg.svh"

module id_operand_mux (
  id_op_if.mux                op,
  input  logic                lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0] lsu_addr_last_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o
);
  import id_pkg::*;

  localparam logic [`ID_XLEN-1:0] ADDR_INCR = `ID_ADDR_INCR;

  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;
  logic [`ID_XLEN-1:0] imm_b;

  // Second access of a misaligned pair is last address plus one word
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD : op.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM : op.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : op.imm_b_sel;

  //////////////////////////////
  // Immediate for operand B
  //////////////////////////////

  always_comb begin
    case (imm_b_sel)
      IMM_B_I: imm_b = op.imm_i;
      IMM_B_S: imm_b = op.imm_s;
      IMM_B_B: imm_b = op.imm_b;
      IMM_B_U: imm_b = op.imm_u;
      IMM_B_J: imm_b = op.imm_j;
      // Link address and next word step by the same amount
      default: imm_b = ADDR_INCR;
    endcase
  end

  //////////////////////////////
  // Operand muxes
  //////////////////////////////

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

// File: decoder/id_decoder.sv
//////////////////////////////
// RV32I base decoder, combinational
// No compressed, CSR, fence or system ops
// Illegal clears write and request flags
//////////////////////////////
`timescale 1ns/10ps
`include "id_cfg.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0]    instr_rdata_i,
  output logic [`ID_RADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0] rf_raddr_b_o,
  output logic [`ID_RADDR_W-1:0] rf_waddr_o,
  id_op_if.dec                   op,
  id_ctrl_if.dec                 ctrl
);
  import id_pkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;

  assign funct7 = instr_rdata_i[31:25];
  assign funct3 = instr_rdata_i[14:12];

  // Register fields sit at fixed positions
  assign rf_raddr_a_o = instr_rdata_i[15 +: `ID_RADDR_W];
  assign rf_raddr_b_o = instr_rdata_i[20 +: `ID_RADDR_W];
  assign rf_waddr_o   = instr_rdata_i[7 +: `ID_RADDR_W];

  //////////////////////////////
  // Immediates
  //////////////////////////////

  // All sign extended from bit 31
  assign op.imm_i = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign op.imm_s = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:25],
                     instr_rdata_i[11:7]};
  assign op.imm_b = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[7],
                     instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign op.imm_u = {instr_rdata_i[31:12], 12'b0};
  assign op.imm_j = {{(`ID_XLEN-20){instr_rdata_i[31]}}, instr_rdata_i[19:12],
                     instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  always_comb begin
    // Defaults describe an I-type ALU op with nothing enabled
    op.alu_operator   = ALU_ADD;
    op.op_a_sel       = OP_A_REG_A;
    op.op_b_sel       = OP_B_IMM;
    op.imm_b_sel      = IMM_B_I;
    ctrl.illegal      = 1'b0;
    ctrl.rf_we        = 1'b0;
    ctrl.rf_ren_a     = 1'b0;
    ctrl.rf_ren_b     = 1'b0;
    ctrl.lsu_req      = 1'b0;
    ctrl.lsu_we       = 1'b0;
    ctrl.lsu_type     = LSU_WORD;
    ctrl.lsu_sign_ext = 1'b0;
    ctrl.branch       = 1'b0;
    ctrl.jump         = 1'b0;

    case (opcode_e'(instr_rdata_i[6:0]))
      // EX adds pc and 4 for the link address
      OPC_JAL, OPC_JALR: begin
        op.op_a_sel   = OP_A_CURRPC;
        op.imm_b_sel  = IMM_B_INCR_PC;
        ctrl.rf_we    = 1'b1;
        ctrl.jump     = 1'b1;
        // JALR also reads rs1 and needs funct3 zero
        if (instr_rdata_i[6:0] == OPC_JALR) begin
          ctrl.rf_ren_a = 1'b1;
          ctrl.illegal  = (funct3 != 3'b000);
        end
      end
      OPC_LUI: begin
        op.op_a_sel  = OP_A_ZERO;
        op.imm_b_sel = IMM_B_U;
        ctrl.rf_we   = 1'b1;
      end
      OPC_AUIPC: begin
        op.op_a_sel  = OP_A_CURRPC;
        op.imm_b_sel = IMM_B_U;
        ctrl.rf_we   = 1'b1;
      end
      // Compare rs1 with rs2, target comes from the B immediate in EX
      OPC_BRANCH: begin
        op.op_b_sel   = OP_B_REG_B;
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.branch   = 1'b1;
        case (funct3)
          3'b000:  op.alu_operator = ALU_EQ;
          3'b001:  op.alu_operator = ALU_NE;
          3'b100:  op.alu_operator = ALU_LT;
          3'b101:  op.alu_operator = ALU_GE;
          3'b110:  op.alu_operator = ALU_LTU;
          3'b111:  op.alu_operator = ALU_GEU;
          default: ctrl.illegal    = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl.rf_ren_a     = 1'b1;
        ctrl.rf_we        = 1'b1;
        ctrl.lsu_req      = 1'b1;
        // funct3[2] marks the unsigned forms
        ctrl.lsu_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: ctrl.lsu_type = LSU_BYTE;
          3'b001, 3'b101: ctrl.lsu_type = LSU_HALF;
          3'b010:         ctrl.lsu_type = LSU_WORD;
          default:        ctrl.illegal  = 1'b1;
        endcase
      end
      OPC_STORE: begin
        op.imm_b_sel  = IMM_B_S;
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.lsu_req  = 1'b1;
        ctrl.lsu_we   = 1'b1;
        case (funct3)
          3'b000:  ctrl.lsu_type = LSU_BYTE;
          3'b001:  ctrl.lsu_type = LSU_HALF;
          3'b010:  ctrl.lsu_type = LSU_WORD;
          default: ctrl.illegal  = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_we    = 1'b1;
        case (funct3)
          3'b000: op.alu_operator = ALU_ADD;
          3'b010: op.alu_operator = ALU_SLT;
          3'b011: op.alu_operator = ALU_SLTU;
          3'b100: op.alu_operator = ALU_XOR;
          3'b110: op.alu_operator = ALU_OR;
          3'b111: op.alu_operator = ALU_AND;
          // Shifts keep funct7 in the top of the immediate
          3'b001: begin
            op.alu_operator = ALU_SLL;
            ctrl.illegal    = (funct7 != 7'b0000000);
          end
          default: begin
            op.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl.illegal    = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPC_OP: begin
        op.op_b_sel   = OP_B_REG_B;
        ctrl.rf_ren_a = 1'b1;
        ctrl.rf_ren_b = 1'b1;
        ctrl.rf_we    = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op.alu_operator = ALU_ADD;
          10'b0100000_000: op.alu_operator = ALU_SUB;
          10'b0000000_001: op.alu_operator = ALU_SLL;
          10'b0000000_010: op.alu_operator = ALU_SLT;
          10'b0000000_011: op.alu_operator = ALU_SLTU;
          10'b0000000_100: op.alu_operator = ALU_XOR;
          10'b0000000_101: op.alu_operator = ALU_SRL;
          10'b0100000_101: op.alu_operator = ALU_SRA;
          10'b0000000_110: op.alu_operator = ALU_OR;
          10'b0000000_111: op.alu_operator = ALU_AND;
          default:         ctrl.illegal    = 1'b1;
        endcase
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // No side effects from an illegal instruction
    if (ctrl.illegal) begin
      ctrl.rf_we   = 1'b0;
      ctrl.lsu_req = 1'b0;
      ctrl.lsu_we  = 1'b0;
      ctrl.branch  = 1'b0;
      ctrl.jump    = 1'b0;
    end
  end

endmodule

// File: common/id_dec_if.sv
//////////////////////////////
// Decoder side bundles
// Raw decode, not qualified by valid
//////////////////////////////
`timescale 1ns/10ps
`include "id_cfg.svh"

// Decoder to operand mux
interface id_op_if;
  import id_pkg::*;

  alu_op_e             alu_operator;
  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  modport dec (output alu_operator, op_a_sel, op_b_sel, imm_b_sel,
               output imm_i, imm_s, imm_b, imm_u, imm_j);
  modport mux (input alu_operator, op_a_sel, op_b_sel, imm_b_sel,
               input imm_i, imm_s, imm_b, imm_u, imm_j);
endinterface

// Decoder to ID/EX controller
interface id_ctrl_if;
  import id_pkg::*;

  logic      illegal;
  logic      rf_we;
  logic      rf_ren_a;
  logic      rf_ren_b;
  logic      lsu_req;
  logic      lsu_we;
  lsu_type_e lsu_type;
  logic      lsu_sign_ext;
  logic      branch;
  logic      jump;

  modport dec (output illegal, rf_we, rf_ren_a, rf_ren_b, lsu_req, lsu_we,
               output lsu_type, lsu_sign_ext, branch, jump);
  modport ctrl (input illegal, rf_we, rf_ren_a, rf_ren_b, lsu_req, lsu_we,
                input lsu_type, lsu_sign_ext, branch, jump);
endinterface

// File: common/id_pkg.sv
//////////////////////////////
// Types of the RV32I decode stage
// Compressed, CSR and mul/div encodings are not covered
//////////////////////////////
package id_pkg;

  // Major opcodes of the kept instruction classes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic, logic and shift ops, then the branch compares
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Operand A source, FWD is the last LSU address
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  // Access size as seen by the LSU
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

// File: common/id_cfg.svh
//////////////////////////////
// Widths of the decode stage
// Only 32-bit data is supported
//////////////////////////////
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data and instruction width
`define ID_XLEN 32

// Register file address width, 32 registers
`define ID_RADDR_W 5

// Next word, also the second access of a misaligned pair
`define ID_ADDR_INCR 4

`endif
